//--- aes_128.f
src/aes_pkg.sv
src/aes_sbox_pkg.sv
src/aes_stage_if.sv
src/aes_sub_word.sv
src/aes_key_expand.sv
src/aes_round.sv
src/aes_128.sv
sim/tb_aes_128.sv

//--- run_sim.sh
#!/bin/sh
# Builds the AES-128 testbench with Verilator and runs it.
# The exit status is the simulator's own.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -j 0 \
    --top-module tb_aes_128 -f aes_128.f -o sim_aes_128
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_aes_128
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit $status
fi
exit 0

//--- sim/aes_vectors.txt
// Each line is one 384-bit word in hex
// Key in the top 128 bits, then plaintext, then expected ciphertext
2b7e151628aed2a6abf7158809cf4f3c3243f6a8885a308d313198a2e03707343925841d02dc09fbdc118597196a0b32
000102030405060708090a0b0c0d0e0f00112233445566778899aabbccddeeff69c4e0d86a7b0430d8cdb78070b4c55a
000000000000000000000000000000000000000000000000000000000000000066e94bd4ef8a2c3b884cfa59ca342b2e
ffffffffffffffffffffffffffffffff00000000000000000000000000000000a1f6258c877d5fcd8964484538bfc92c
00000000000000000000000000000000ffffffffffffffffffffffffffffffff3f5b8cc9ea855a0afa7347d23e8d664e
2b7e151628aed2a6abf7158809cf4f3c6bc1bee22e409f96e93d7e117393172a3ad77bb40d7a3660a89ecaf32466ef97
2b7e151628aed2a6abf7158809cf4f3cae2d8a571e03ac9c9eb76fac45af8e51f5d3d58503b9699de785895a96fdbaaf
2b7e151628aed2a6abf7158809cf4f3c30c81c46a35ce411e5fbc1191a0a52ef43b1cd7f598ece23881b00e3ed030688
2b7e151628aed2a6abf7158809cf4f3cf69f2445df4f9b17ad2b417be66c37107b0c785e27e8ad3f8223207104725dd4
00000000000000000000000000000000f34481ec3cc627bacd5dc3fb08f273e60336763e966d92595a567cc9ce537f5e
000000000000000000000000000000009798c4640bad75c7c3227db910174e72a9a1631bf4996954ebc093957b234589
0000000000000000000000000000000096ab5c2ff612d9dfaae8c31f30c42168ff4f8391a6a40ca5b25d23bedd44a597
000000000000000000000000000000006a118a874519e64e9963798a503f1d35dc43be40be0e53712f7e2bf5ca707209
00000000000000000000000000000000cb9fceec81286ca3e989bd979b0cb28492beedab1895a94faa69b632e5cc47ce
00000000000000000000000000000000b26aeb1874e47ca8358ff22378f09144459264f4798f6a78bacb89c15ed3d601
0000000000000000000000000000000058c8e00b2631686d54eab84b91f0aca108a4e2efec8a8e3312ca7460b9040bbf
10a58869d74be5a374cf867cfb473859000000000000000000000000000000006d251e6944b051e04eaa6fb4dbf78465
caea65cdbb75e9169ecd22ebe6e54675000000000000000000000000000000006e29201190152df4ee058139def610bb
a2e2fa9baf7d20822ca9f0542f764a4100000000000000000000000000000000c3b44b95d9d2f25670eee9a0de099fa3
b6364ac4e1de1e285eaf144a2415f7a0000000000000000000000000000000005d9b05578fc944b3cf1ccf0e746cd581
00000000000000000000000000000000800000000000000000000000000000003ad78e726c1ec02b7ebfe92b23d9ec34
80000000000000000000000000000000000000000000000000000000000000000edd33d3c621e546455bd8ba1418bec8

//--- sim/tb_aes_128.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench for the AES-128 core
// Known-answer vectors, burst and stall phases
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_aes_128;

    localparam int clk_period = 10;
    localparam int n_vec = 22;
    // Single block, burst of the rest, then every vector again under stalls
    localparam int n_blocks = 2 * n_vec;
    // Key add cycle plus two cycles for each of ten rounds
    localparam int latency = 1 + 2 * 10;
    localparam int timeout_cycles = n_blocks * 4 + 200;
    localparam int seed = 98;

    logic         clk;
    logic         rst_n;
    logic         in_valid;
    logic         in_ready;
    logic [127:0] plaintext;
    logic [127:0] key;
    logic         out_valid;
    logic         out_ready;
    logic [127:0] ciphertext;

    logic [383:0] vec [0:n_vec-1];
    bit           stall_pat [0:timeout_cycles-1];
    int           gap_len [0:n_vec-1];
    int           idx_q [$];
    int           acc_q [$];
    int           drive_idx;
    int           cycle;
    int           in_count;
    int           out_count;
    int           last_out;
    int           burst_outs;
    bit           fixed_timing;
    bit           burst;
    bit           prev_stall;
    logic [127:0] prev_ct;

    aes_128 dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .plaintext  (plaintext),
        .key        (key),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .ciphertext (ciphertext)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic stop_run;
        $display("Simulation failed");
        $fatal(1, "run stopped on the first failure");
    endtask

    task automatic check(input string name, input logic [127:0] got,
                         input logic [127:0] exp);
        if (got !== exp)
        begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // Pops the oldest accepted block and compares its ciphertext
    task automatic score_output;
        int idx;
        int acc;
        if (idx_q.size() == 0)
        begin
            $display("An output appeared while no block was in the pipeline");
            stop_run();
        end
        else
        begin
            idx = idx_q.pop_front();
            acc = acc_q.pop_front();
            check("ciphertext", ciphertext, vec[idx][127:0]);
            if (fixed_timing)
                check("latency", 128'(cycle - acc), 128'(latency));
            if (burst && burst_outs > 0)
                check("output spacing", 128'(cycle - last_out), 128'(1));
            if (burst)
                burst_outs++;
            last_out = cycle;
            out_count++;
        end
    endtask

    // Monitor samples 1 ns before each rising edge
    initial
    begin
        forever
        begin
            @(negedge clk);
            #(clk_period / 2 - 1);
            cycle++;
            if (rst_n)
            begin
                if (prev_stall)
                begin
                    check("out_valid", 128'(out_valid), 128'(1));
                    check("ciphertext", ciphertext, prev_ct);
                end
                prev_stall = out_valid && !out_ready;
                prev_ct = ciphertext;
                if (prev_stall)
                    check("in_ready", 128'(in_ready), 128'(0));
                if (burst)
                    check("in_ready", 128'(in_ready), 128'(1));
                if (in_valid && in_ready)
                begin
                    idx_q.push_back(drive_idx);
                    acc_q.push_back(cycle);
                    in_count++;
                end
                if (out_valid && out_ready)
                    score_output();
            end
        end
    end

    // Holds one block on the inputs until the monitor has seen it accepted
    task automatic send_block(input int idx);
        int target;
        target = in_count + 1;
        in_valid = 1'b1;
        key = vec[idx][383:256];
        plaintext = vec[idx][255:128];
        drive_idx = idx;
        @(negedge clk);
        while (in_count != target)
            @(negedge clk);
    endtask

    task automatic idle_cycles(input int n);
        if (n > 0)
        begin
            in_valid = 1'b0;
            // Junk on the data inputs while idle
            plaintext = {$urandom, $urandom, $urandom, $urandom};
            key = {$urandom, $urandom, $urandom, $urandom};
            repeat (n) @(negedge clk);
        end
    endtask

    task automatic wait_outputs(input int n);
        while (out_count < n)
            @(negedge clk);
    endtask

    initial
    begin
        #(timeout_cycles * clk_period);
        $display("Run timed out after %0d cycles with %0d of %0d blocks checked",
                 timeout_cycles, out_count, n_blocks);
        stop_run();
    end

    initial
    begin
        int junk;
        int k;
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        out_ready = 1'b1;
        plaintext = '0;
        key = '0;
        junk = $urandom(seed);
        $readmemh("sim/aes_vectors.txt", vec);
        if ($isunknown(vec[n_vec-1]))
        begin
            $display("Vector file sim/aes_vectors.txt is missing or has too few lines");
            stop_run();
        end
        // Random schedule drawn up front
        for (int i = 0; i < n_vec; i++)
            gap_len[i] = $urandom % 3;
        for (int c = 0; c < timeout_cycles; c++)
            stall_pat[c] = ($urandom % 4) == 0;

        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check("out_valid", 128'(out_valid), 128'(0));
        check("in_ready", 128'(in_ready), 128'(1));

        // One block into an empty pipeline
        fixed_timing = 1'b1;
        send_block(0);
        in_valid = 1'b0;
        wait_outputs(1);

        // Back-to-back blocks, one output per cycle expected
        burst = 1'b1;
        for (int i = 1; i < n_vec; i++)
            send_block(i);
        in_valid = 1'b0;
        wait_outputs(n_vec);
        burst = 1'b0;
        fixed_timing = 1'b0;

        // Idle gaps on the input and random stalls on the output
        fork
            begin
                for (int i = 0; i < n_vec; i++)
                begin
                    idle_cycles(gap_len[i]);
                    send_block(i);
                end
                in_valid = 1'b0;
            end
            begin
                k = 0;
                while (out_count < n_blocks)
                begin
                    out_ready = !stall_pat[k % timeout_cycles];
                    k++;
                    @(negedge clk);
                end
                out_ready = 1'b1;
            end
        join

        // Quiet time so a duplicated block would still show up
        repeat (latency + 4) @(negedge clk);
        if (in_count == n_blocks && out_count == n_blocks && idx_q.size() == 0)
        begin
            $display("Simulation passed");
            $finish;
        end
        else
        begin
            $display("Block counts differ, %0d sent, %0d accepted, %0d received",
                     n_blocks, in_count, out_count);
            stop_run();
        end
    end

endmodule

//--- src/aes_128.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AES-128 encryption core, fully pipelined
// valid/ready handshake with one global stall
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module aes_128 (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic [aes_pkg::block_w-1:0] plaintext,
    input  logic [aes_pkg::block_w-1:0] key,
    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [aes_pkg::block_w-1:0] ciphertext
);
    import aes_pkg::*;

    logic                    advance;
    logic                    accept;
    logic [pipe_latency-1:0] valid_sr;
    logic [block_w-1:0]      state_q;
    logic [block_w-1:0]      key_q;

    // Stage i feeds round i+1, the last one holds the ciphertext
    aes_stage_if st [0:n_rounds] ();

    // Whole pipeline moves unless a finished block is waiting
    assign advance  = !out_valid || out_ready;
    assign in_ready = advance;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_sr <= '0;
        end
        else if (advance)
        begin
            valid_sr <= {valid_sr[pipe_latency-2:0], in_valid};
        end
    end

    assign out_valid = valid_sr[pipe_latency-1];

    // Initial AddRoundKey and key capture
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            state_q <= plaintext ^ key;
            key_q   <= key;
        end
    end

    assign st[0].block = state_q;
    assign st[0].key   = key_q;

    for (genvar i = 0; i <= n_rounds; i++)
    begin : g_enable
        assign st[i].advance = advance;
    end

    for (genvar i = 0; i < n_rounds; i++)
    begin : g_stage
        aes_key_expand key_expand_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .advance   (advance),
            .rcon_byte (rcon[i]),
            .key_in    (st[i].key),
            .key_out   (st[i+1].key),
            .round_key (st[i].round_key)
        );

        if (i < n_rounds - 1)
        begin : g_full
            aes_round #(
                .is_final (1'b0)
            ) round_i (
                .clk   (clk),
                .rst_n (rst_n),
                .up    (st[i]),
                .down  (st[i+1])
            );
        end
        else
        begin : g_final
            aes_round #(
                .is_final (1'b1)
            ) round_i (
                .clk   (clk),
                .rst_n (rst_n),
                .up    (st[i]),
                .down  (st[i+1])
            );
        end
    end

    // No round follows the last stage
    assign st[n_rounds].round_key = '0;

    assign ciphertext = st[n_rounds].block;

    // Output held steady while the sink stalls
    out_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(ciphertext) && $stable(out_valid));

endmodule

//--- src/aes_key_expand.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One AES-128 key schedule step, two cycles deep
// Gives the round key early and the next key late
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module aes_key_expand (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        advance,
    input  logic [7:0]                  rcon_byte,
    input  logic [aes_pkg::block_w-1:0] key_in,
    output logic [aes_pkg::block_w-1:0] key_out,
    output logic [aes_pkg::block_w-1:0] round_key
);
    import aes_pkg::*;

    aes_block_u  key_u;
    aes_block_u  chain_d;
    aes_block_u  chain_q;
    aes_block_u  next_u;
    logic [31:0] rot_word;
    logic [31:0] sub_q;

    function automatic logic is_rcon(input logic [7:0] b);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < n_rounds; i++)
        begin
            hit = hit | (b == rcon[i]);
        end
        return hit;
    endfunction

    assign key_u = key_in;

    // Running XOR of the key words, rcon folded into word 0.
    // cols[3] is word 0, cols[0] is word 3
    always_comb
    begin
        chain_d.cols[3] = key_u.cols[3] ^ {rcon_byte, 24'h000000};
        chain_d.cols[2] = chain_d.cols[3] ^ key_u.cols[2];
        chain_d.cols[1] = chain_d.cols[2] ^ key_u.cols[1];
        chain_d.cols[0] = chain_d.cols[1] ^ key_u.cols[0];
    end

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            chain_q <= chain_d;
        end
    end

    // RotWord of the last word
    assign rot_word = {key_u.cols[0][23:0], key_u.cols[0][31:24]};

    aes_sub_word sub_word_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .advance  (advance),
        .word_in  (rot_word),
        .word_out (sub_q)
    );

    always_comb
    begin
        for (int j = 0; j < 4; j++)
        begin
            next_u.cols[j] = chain_q.cols[j] ^ sub_q;
        end
    end

    assign round_key = next_u;

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            key_out <= next_u;
        end
    end

    // Each stage must be tied to a real schedule constant
    rcon_legal_a : assert property (@(posedge clk) disable iff (!rst_n)
        is_rcon(rcon_byte));

endmodule

//--- src/aes_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AES-128 cipher constants and round constants
// Block type with byte and column views
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package aes_pkg;

    // Block and key width
    localparam int block_w = 128;
    localparam int n_rounds = 10;

    // Initial key add plus two cycles per round
    localparam int pipe_latency = 1 + 2 * n_rounds;

    // Key schedule round constants, entry i feeds expansion stage i
    localparam logic [7:0] rcon [0:n_rounds-1] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    // One state block seen two ways.
    // bytes[15] is state byte 0 (the first input byte), cols[3] is column 0.
    // Row r of a column sits at bits [31-8r -: 8] of that column.
    typedef union packed {
        logic [15:0][7:0] bytes;
        logic [3:0][31:0] cols;
    } aes_block_u;

endpackage

//--- src/aes_round.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One cipher round, S-box stage then output stage
// MixColumns bypassed in the final round
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module aes_round #(
    parameter bit is_final = 1'b0
) (
    input logic      clk,
    input logic      rst_n,
    aes_stage_if.dst up,
    aes_stage_if.src down
);
    import aes_pkg::*;
    import aes_sbox_pkg::*;

    aes_block_u sb_d;
    aes_block_u sb_q;
    aes_block_u sr;
    aes_block_u mc;
    aes_block_u out_q;

    function automatic logic [31:0] mix_column(input logic [31:0] col);
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    endfunction

    // Cycle one: SubBytes on all sixteen bytes
    always_comb
    begin
        for (int i = 0; i < 16; i++)
        begin
            sb_d.bytes[i] = sub_byte(up.block.bytes[i]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (up.advance)
        begin
            sb_q <= sb_d;
        end
    end

    // ShiftRows, row r rotates left by r columns.
    // State byte k lives at bytes[15-k]
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                sr.bytes[15 - (4*c + r)] = sb_q.bytes[15 - (4*((c + r) % 4) + r)];
            end
        end
    end

    always_comb
    begin
        for (int j = 0; j < 4; j++)
        begin
            mc.cols[j] = is_final ? sr.cols[j] : mix_column(sr.cols[j]);
        end
    end

    // Cycle two: AddRoundKey, the round key arrives one cycle behind the block
    always_ff @(posedge clk)
    begin
        if (up.advance)
        begin
            out_q <= mc ^ up.round_key;
        end
    end

    assign down.block = out_q;

    // A stall freezes what the next stage sees
    hold_on_stall_a : assert property (@(posedge clk) disable iff (!rst_n)
        !up.advance |=> $stable(down.block));

endmodule

//--- src/aes_sbox_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Forward S-box table and byte lookup
// GF(2^8) doubling for MixColumns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package aes_sbox_pkg;

    // Forward substitution table, row-major by input byte
    localparam logic [7:0] sbox [0:255] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    function automatic logic [7:0] sub_byte(input logic [7:0] b);
        return sbox[b];
    endfunction

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

endpackage

//--- src/aes_stage_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Link between pipeline stages: state block,
// round key, key schedule word and stage enable
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

interface aes_stage_if;
    import aes_pkg::*;

    aes_block_u block;
    // Key for the round that consumes this stage, one cycle behind block
    logic [block_w-1:0] round_key;
    // Key schedule state, in step with block
    logic [block_w-1:0] key;
    logic advance;

    modport src (
        output block,
        output round_key,
        output key,
        input  advance
    );

    modport dst (
        input block,
        input round_key,
        input key,
        input advance
    );

endinterface

//--- src/aes_sub_word.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Registered S-box lookup of one 32-bit key word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module aes_sub_word (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        advance,
    input  logic [31:0] word_in,
    output logic [31:0] word_out
);
    import aes_sbox_pkg::*;

    logic [31:0] word_d;

    // Four parallel byte lookups
    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            word_d[8*i +: 8] = sub_byte(word_in[8*i +: 8]);
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            word_out <= '0;
        end
        else if (advance)
        begin
            word_out <= word_d;
        end
    end

endmodule
